/* filelist.f */
+incdir+common
common/lsu_pkg.sv
lsu/lsu_lane_align.sv
lsu/lsu_ctrl.sv
hdl/lsu_region_cfg.sv
hdl/axi_lite_sram.sv
hdl/mem_stage_top.sv
verif/mem_stage_properties.sv
verif/tb_mem_stage.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= tb_mem_stage
RTL_TOP    ?= mem_stage_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_mem_stage.sv */
// self-checking testbench for mem_stage_top; LFSR-driven requests compared against a byte-level model
`include "lsu_config.svh"

module tb_mem_stage;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 10;
	localparam int N_RAND = 150;
	// init stores, two random phases and a margin for the directed requests
	localparam int N_REQ = `SRAM_WORDS + 2 * N_RAND + 32;
	localparam int WATCHDOG_CYCLES = N_REQ * 20;

	logic clock;
	logic rstn;
	logic req_valid_i;
	lsu_pkg::lsu_req_t req_i;
	logic req_ready_o;
	logic rsp_valid_o;
	lsu_pkg::lsu_rsp_t rsp_o;
	logic rsp_ready_i;
	logic cfg_valid_i;
	logic cfg_sel_i;
	logic [`ADDR_LEN-1:0] cfg_wdata_i;
	lsu_pkg::win_cfg_t win_o;

	// reference model state
	logic [7:0] model_mem [`SRAM_WORDS * 4];
	logic [`ADDR_LEN-1:0] win_base;
	logic [`ADDR_LEN-1:0] win_limit;
	lsu_pkg::lsu_rsp_t exp_q[$];

	logic [15:0] lfsr_state = 16'd16;
	logic req_taken;
	logic held;
	lsu_pkg::lsu_rsp_t held_rsp;
	int rsp_count;

	mem_stage_top DUT (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.req_ready_o (req_ready_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o),
		.rsp_ready_i (rsp_ready_i),
		.cfg_valid_i (cfg_valid_i),
		.cfg_sel_i   (cfg_sel_i),
		.cfg_wdata_i (cfg_wdata_i),
		.win_o       (win_o)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// 16-bit Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic lsu_pkg::lsu_req_t make_req(input lsu_pkg::mem_op_e op,
			input logic [31:0] addr, input logic [31:0] data);
		lsu_pkg::lsu_req_t r;
		r.op = op;
		r.addr = addr;
		r.wdata = data;
		r.rd = 5'(rand_bits(5));
		r.wd = lfsr_bit();
		return r;
	endfunction

	function automatic lsu_pkg::lsu_req_t random_req();
		lsu_pkg::lsu_req_t r;
		logic [3:0] pick;
		logic [7:0] where;
		pick = 4'(rand_bits(4));
		r.op = lsu_pkg::mem_op_e'(pick % 4'd9);
		where = 8'(rand_bits(8));
		// roughly 80% inside the SRAM
		if (where < 8'd205)
			r.addr = rand_bits(16) % (`SRAM_WORDS * 4);
		else
			r.addr = (`SRAM_WORDS * 4) + rand_bits(14);
		// natural alignment keeps every access inside one word
		if (r.op inside {lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH})
			r.addr[0] = 1'b0;
		else if (r.op inside {lsu_pkg::OP_LW, lsu_pkg::OP_SW})
			r.addr[1:0] = 2'b00;
		r.wdata = rand_bits(32);
		r.rd = 5'(rand_bits(5));
		r.wd = lfsr_bit();
		return r;
	endfunction

	// expected writeback for one request; applies stores to the model
	function automatic lsu_pkg::lsu_rsp_t model_access(input lsu_pkg::lsu_req_t r);
		lsu_pkg::lsu_rsp_t e;
		logic ok;
		logic [1:0] lane;
		int idx0;
		int nbytes;
		logic [31:0] raw;
		e.rd = r.rd;
		e.wd = r.wd;
		e.wdata = r.wdata;
		e.err = 1'b0;
		if (r.op == lsu_pkg::OP_NONE)
			return e;
		ok = (r.addr < 32'(`SRAM_WORDS * 4));
		// device-style access outside the window sits at lane 0
		lane = ((r.addr >= win_base) && (r.addr <= win_limit)) ? r.addr[1:0] : 2'b00;
		idx0 = int'(r.addr & ~32'h3) + int'(lane);
		case (r.op)
			lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: nbytes = 1;
			lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: nbytes = 2;
			default: nbytes = 4;
		endcase
		e.err = !ok;
		raw = '0;
		for (int k = 0; k < nbytes; k++) begin
			if (ok && (r.op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW}))
				model_mem[idx0 + k] = r.wdata[8*k +: 8];
			else if (ok)
				raw[8*k +: 8] = model_mem[idx0 + k];
		end
		// unused upper bytes of raw stay zero, which covers LBU and LHU
		case (r.op)
			lsu_pkg::OP_LB: e.wdata = {{24{raw[7]}}, raw[7:0]};
			lsu_pkg::OP_LH: e.wdata = {{16{raw[15]}}, raw[15:0]};
			lsu_pkg::OP_LBU, lsu_pkg::OP_LHU, lsu_pkg::OP_LW: e.wdata = raw;
			default: e.wdata = r.wdata;
		endcase
		return e;
	endfunction

	function automatic lsu_pkg::win_cfg_t current_win();
		lsu_pkg::win_cfg_t w;
		w.base = win_base;
		w.limit = win_limit;
		return w;
	endfunction

	function automatic string rsp_text(input lsu_pkg::lsu_rsp_t r);
		return $sformatf("rd=%0d wd=%0b data=%h err=%0b", r.rd, r.wd, r.wdata, r.err);
	endfunction

	function automatic string win_text(input lsu_pkg::win_cfg_t w);
		return $sformatf("base=%h limit=%h", w.base, w.limit);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_rsp(input lsu_pkg::lsu_rsp_t got, input lsu_pkg::lsu_rsp_t want,
			input string what);
		if (got !== want)
			abort_run($sformatf("** Error @ %0d ns: %s: got %s, expected %s",
				$time, what, rsp_text(got), rsp_text(want)));
	endtask

	task automatic check_win(input lsu_pkg::win_cfg_t got, input lsu_pkg::win_cfg_t want,
			input string what);
		if (got !== want)
			abort_run($sformatf("** Error @ %0d ns: %s: got %s, expected %s",
				$time, what, win_text(got), win_text(want)));
	endtask

	// sample at the falling edge and drive 1 ns after the rising edge
	task automatic next_cycle();
		lsu_pkg::lsu_rsp_t want;
		@(negedge clock);
		if (rsp_valid_o) begin
			if (exp_q.size() == 0)
				abort_run("a response arrived with no request outstanding");
			if (held && (rsp_o !== held_rsp))
				abort_run("a stalled response changed before it was accepted");
			if (rsp_ready_i) begin
				want = exp_q.pop_front();
				check_rsp(rsp_o, want, $sformatf("response %0d", rsp_count));
				rsp_count++;
				held = 1'b0;
			end else begin
				held = 1'b1;
				held_rsp = rsp_o;
			end
		end else if (held) begin
			abort_run("response valid dropped before the response was accepted");
		end
		req_taken = req_valid_i && req_ready_o;
		@(posedge clock);
		#1;
		// stall writeback on about a quarter of the cycles
		rsp_ready_i = (2'(rand_bits(2)) != 2'b00);
	endtask

	task automatic issue(input lsu_pkg::lsu_req_t r);
		req_i = r;
		req_valid_i = 1'b1;
		req_taken = 1'b0;
		while (!req_taken)
			next_cycle();
		req_valid_i = 1'b0;
		exp_q.push_back(model_access(r));
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			next_cycle();
	endtask

	task automatic write_cfg(input logic sel, input logic [31:0] value);
		cfg_valid_i = 1'b1;
		cfg_sel_i = sel;
		cfg_wdata_i = value;
		next_cycle();
		cfg_valid_i = 1'b0;
		if (sel)
			win_limit = value;
		else
			win_base = value;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		clock = 1'b0;
		rstn = 1'b0;
		req_valid_i = 1'b0;
		req_i = '0;
		rsp_ready_i = 1'b0;
		cfg_valid_i = 1'b0;
		cfg_sel_i = 1'b0;
		cfg_wdata_i = '0;
		win_base = `WIN_BASE_RST;
		win_limit = `WIN_LIMIT_RST;
		held = 1'b0;
		rsp_count = 0;
		repeat (3) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(negedge clock);
		if (!req_ready_o || rsp_valid_o)
			abort_run("request ready or response valid is wrong after reset");
		check_win(win_o, current_win(), "window after reset");
		@(posedge clock);
		#1;

		// pass-through
		issue(make_req(lsu_pkg::OP_NONE, 32'h0000_0040, 32'hDEAD_BEEF));
		issue(make_req(lsu_pkg::OP_NONE, 32'h1234_5678, 32'h0000_0001));

		// fill every word so the model starts in step with the SRAM
		for (int w = 0; w < `SRAM_WORDS; w++)
			issue(make_req(lsu_pkg::OP_SW, 32'(w * 4), rand_bits(32)));

		// lane shifts and extension inside the window
		issue(make_req(lsu_pkg::OP_SW, 32'h0000_0010, 32'h8899_A5BB));
		issue(make_req(lsu_pkg::OP_LB, 32'h0000_0013, 32'h0));
		issue(make_req(lsu_pkg::OP_LBU, 32'h0000_0013, 32'h0));
		issue(make_req(lsu_pkg::OP_LH, 32'h0000_0012, 32'h0));
		issue(make_req(lsu_pkg::OP_LHU, 32'h0000_0012, 32'h0));
		issue(make_req(lsu_pkg::OP_SB, 32'h0000_0015, 32'h0000_00E7));
		issue(make_req(lsu_pkg::OP_SH, 32'h0000_001A, 32'h0000_F00D));
		issue(make_req(lsu_pkg::OP_LW, 32'h0000_0014, 32'h0));
		issue(make_req(lsu_pkg::OP_LW, 32'h0000_0018, 32'h0));
		repeat (N_RAND) issue(random_req());
		drain();

		// beyond the SRAM; 0x100 aliases word 0 in the index bits
		issue(make_req(lsu_pkg::OP_SW, 32'h0000_0100, 32'hFFFF_FFFF));
		issue(make_req(lsu_pkg::OP_LW, 32'h0000_0100, 32'h0));
		issue(make_req(lsu_pkg::OP_LB, 32'h0000_0101, 32'h0));
		issue(make_req(lsu_pkg::OP_LW, 32'h0000_0000, 32'h0));
		drain();

		// shrink the window to 0x80..0xBF
		write_cfg(1'b0, 32'h0000_0080);
		write_cfg(1'b1, 32'h0000_00BF);
		check_win(win_o, current_win(), "window after reprogramming");

		// sub-word traffic outside the window lands on lane 0
		issue(make_req(lsu_pkg::OP_SB, 32'h0000_0043, 32'h0000_005A));
		issue(make_req(lsu_pkg::OP_LBU, 32'h0000_0043, 32'h0));
		issue(make_req(lsu_pkg::OP_LW, 32'h0000_0040, 32'h0));
		issue(make_req(lsu_pkg::OP_SH, 32'h0000_00C2, 32'h0000_8001));
		issue(make_req(lsu_pkg::OP_LH, 32'h0000_00C2, 32'h0));
		issue(make_req(lsu_pkg::OP_LW, 32'h0000_00C0, 32'h0));
		repeat (N_RAND) issue(random_req());
		drain();

		// no stray response may follow the last one
		repeat (4) next_cycle();
		@(negedge clock);
		if (rsp_valid_o || !req_ready_o)
			abort_run("the stage did not return to idle after the last response");

		if (DUT.u_ctrl.u_props.fail_count != 0) begin
			abort_run($sformatf("%0d handshake assertions failed",
				DUT.u_ctrl.u_props.fail_count));
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* verif/mem_stage_properties.sv */
// handshake assertions for the memory stage controller; bound into every lsu_ctrl instance
`include "lsu_config.svh"

module mem_stage_properties (
	input logic clock,
	input logic rstn,
	input logic req_ready_i,
	input logic rsp_valid_i,
	input logic rsp_ready_i,
	input lsu_pkg::lsu_rsp_t rsp_i,
	input logic arvalid_i,
	input logic arready_i,
	input logic [`ADDR_LEN-1:0] araddr_i,
	input logic awvalid_i,
	input logic awready_i,
	input logic [`ADDR_LEN-1:0] awaddr_i,
	input logic wvalid_i,
	input logic wready_i,
	input logic [`DATA_LEN-1:0] wdata_i,
	input logic [`DATA_LEN/8-1:0] wstrb_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;

	// a raised valid keeps its payload until ready
	ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
		else begin
			$error("read address dropped or changed before arready");
			fail_count++;
		end

	aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
		else begin
			$error("write address dropped or changed before awready");
			fail_count++;
		end

	w_hold: assert property (@(posedge clock) disable iff (!rstn)
		wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
		else begin
			$error("write data dropped or changed before wready");
			fail_count++;
		end

	rsp_hold: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
		else begin
			$error("writeback record dropped or changed before rsp_ready");
			fail_count++;
		end

	// one request at a time, ready returns only once the response is taken
	no_req_with_rsp: assert property (@(posedge clock) disable iff (!rstn)
		$rose(req_ready_i) |-> $past(rsp_valid_i && rsp_ready_i))
		else begin
			$error("request ready returned without an accepted response");
			fail_count++;
		end

endmodule

bind lsu_ctrl mem_stage_properties u_props (
	.clock       (clock),
	.rstn        (rstn),
	.req_ready_i (req_ready_o),
	.rsp_valid_i (rsp_valid_o),
	.rsp_ready_i (rsp_ready_i),
	.rsp_i       (rsp_o),
	.arvalid_i   (arvalid_o),
	.arready_i   (arready_i),
	.araddr_i    (araddr_o),
	.awvalid_i   (awvalid_o),
	.awready_i   (awready_i),
	.awaddr_i    (awaddr_o),
	.wvalid_i    (wvalid_o),
	.wready_i    (wready_i),
	.wdata_i     (wdata_o),
	.wstrb_i     (wstrb_o)
);

/* hdl/mem_stage_top.sv */
// memory stage top; controller, lane aligner and window registers in front of the AXI-lite SRAM
`include "lsu_config.svh"

module mem_stage_top (
	input  logic clock,
	input  logic rstn,
	input  logic req_valid_i,
	input  lsu_pkg::lsu_req_t req_i,
	output logic req_ready_o,
	output logic rsp_valid_o,
	output lsu_pkg::lsu_rsp_t rsp_o,
	input  logic rsp_ready_i,
	input  logic cfg_valid_i,
	input  logic cfg_sel_i,
	input  logic [`ADDR_LEN-1:0] cfg_wdata_i,
	output lsu_pkg::win_cfg_t win_o
);

	logic [`ADDR_LEN-1:0] araddr;
	lsu_pkg::axi_size_e arsize;
	logic arvalid;
	logic arready;
	logic [`DATA_LEN-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [`ADDR_LEN-1:0] awaddr;
	lsu_pkg::axi_size_e awsize;
	logic awvalid;
	logic awready;
	logic [`DATA_LEN-1:0] wdata;
	logic [`DATA_LEN/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	lsu_pkg::mem_op_e al_op;
	logic [`ADDR_LEN-1:0] al_addr;
	logic [`DATA_LEN-1:0] al_wdata;
	logic [`DATA_LEN-1:0] al_rdata;
	logic [`DATA_LEN-1:0] al_lane_wdata;
	logic [`DATA_LEN/8-1:0] al_strb;
	logic [`DATA_LEN-1:0] al_load;
	logic in_window;

	lsu_ctrl u_ctrl (
		.clock           (clock),
		.rstn            (rstn),
		.req_valid_i     (req_valid_i),
		.req_i           (req_i),
		.req_ready_o     (req_ready_o),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_o           (rsp_o),
		.rsp_ready_i     (rsp_ready_i),
		.araddr_o        (araddr),
		.arsize_o        (arsize),
		.arvalid_o       (arvalid),
		.arready_i       (arready),
		.rdata_i         (rdata),
		.rresp_i         (rresp),
		.rvalid_i        (rvalid),
		.rready_o        (rready),
		.awaddr_o        (awaddr),
		.awsize_o        (awsize),
		.awvalid_o       (awvalid),
		.awready_i       (awready),
		.wdata_o         (wdata),
		.wstrb_o         (wstrb),
		.wvalid_o        (wvalid),
		.wready_i        (wready),
		.bresp_i         (bresp),
		.bvalid_i        (bvalid),
		.bready_o        (bready),
		.al_op_o         (al_op),
		.al_addr_o       (al_addr),
		.al_wdata_o      (al_wdata),
		.al_rdata_o      (al_rdata),
		.al_lane_wdata_i (al_lane_wdata),
		.al_strb_i       (al_strb),
		.al_load_i       (al_load)
	);

	lsu_lane_align u_align (
		.op_i         (al_op),
		.addr_lo_i    (al_addr[1:0]),
		.in_window_i  (in_window),
		.wdata_i      (al_wdata),
		.rdata_i      (al_rdata),
		.lane_wdata_o (al_lane_wdata),
		.strb_o       (al_strb),
		.load_o       (al_load)
	);

	lsu_region_cfg u_region (
		.clock       (clock),
		.rstn        (rstn),
		.cfg_valid_i (cfg_valid_i),
		.cfg_sel_i   (cfg_sel_i),
		.cfg_wdata_i (cfg_wdata_i),
		.addr_i      (al_addr),
		.win_o       (win_o),
		.in_window_o (in_window)
	);

	axi_lite_sram u_sram (
		.clock     (clock),
		.rstn      (rstn),
		.araddr_i  (araddr),
		.arsize_i  (arsize),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.awaddr_i  (awaddr),
		.awsize_i  (awsize),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.bresp_o   (bresp),
		.bvalid_o  (bvalid),
		.bready_i  (bready)
	);

endmodule

/* hdl/axi_lite_sram.sv */
// word-addressed AXI-lite slave memory with byte strobes; SLVERR for addresses past the depth
`include "lsu_config.svh"

module axi_lite_sram (
	input  logic clock,
	input  logic rstn,
	// address read
	input  logic [`ADDR_LEN-1:0] araddr_i,
	input  lsu_pkg::axi_size_e arsize_i,
	input  logic arvalid_i,
	output logic arready_o,
	// read data
	output logic [`DATA_LEN-1:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	input  logic rready_i,
	// address write
	input  logic [`ADDR_LEN-1:0] awaddr_i,
	input  lsu_pkg::axi_size_e awsize_i,
	input  logic awvalid_i,
	output logic awready_o,
	// write data
	input  logic [`DATA_LEN-1:0] wdata_i,
	input  logic [`DATA_LEN/8-1:0] wstrb_i,
	input  logic wvalid_i,
	output logic wready_o,
	// write response
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input  logic bready_i
);

	localparam int unsigned IDX_W = $clog2(`SRAM_WORDS);
	localparam int unsigned WORD_AW = `ADDR_LEN - 2;

	logic [`DATA_LEN-1:0] mem [`SRAM_WORDS];

	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic ar_ok;
	logic aw_got;
	logic w_got;
	logic [`ADDR_LEN-1:0] aw_addr_q;
	lsu_pkg::axi_size_e aw_size_q;
	logic [`DATA_LEN-1:0] w_data_q;
	logic [`DATA_LEN/8-1:0] w_strb_q;
	logic [`ADDR_LEN-1:0] wr_addr;
	lsu_pkg::axi_size_e wr_size;
	logic [`DATA_LEN-1:0] wr_data;
	logic [`DATA_LEN/8-1:0] wr_strb;
	logic wr_fire;
	logic wr_ok;

	assign ar_hs = arvalid_i && arready_o;
	assign aw_hs = awvalid_i && awready_o;
	assign w_hs = wvalid_i && wready_o;

	// in range and no wider than the bus
	assign ar_ok = (araddr_i[`ADDR_LEN-1:2] < WORD_AW'(`SRAM_WORDS))
		&& (arsize_i <= lsu_pkg::AXI_SIZE_4);

	// address and data may arrive in either order; use the live beat if not held
	assign wr_addr = aw_got ? aw_addr_q : awaddr_i;
	assign wr_size = aw_got ? aw_size_q : awsize_i;
	assign wr_data = w_got ? w_data_q : wdata_i;
	assign wr_strb = w_got ? w_strb_q : wstrb_i;
	assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs) && !bvalid_o;
	assign wr_ok = (wr_addr[`ADDR_LEN-1:2] < WORD_AW'(`SRAM_WORDS))
		&& (wr_size <= lsu_pkg::AXI_SIZE_4);

	// handshake control
	always_ff @(posedge clock) begin
		if (!rstn) begin
			arready_o <= 1'b0;
			rvalid_o <= 1'b0;
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			bvalid_o <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
		end else begin
			// ready answers one cycle after valid, as a single pulse
			arready_o <= arvalid_i && !arready_o && !rvalid_o;
			awready_o <= awvalid_i && !awready_o && !aw_got;
			wready_o <= wvalid_i && !wready_o && !w_got;

			if (ar_hs)
				rvalid_o <= 1'b1;
			else if (rvalid_o && rready_i)
				rvalid_o <= 1'b0;

			if (bvalid_o && bready_i)
				bvalid_o <= 1'b0;
			if (wr_fire) begin
				aw_got <= 1'b0;
				w_got <= 1'b0;
				bvalid_o <= 1'b1;
			end else begin
				if (aw_hs)
					aw_got <= 1'b1;
				if (w_hs)
					w_got <= 1'b1;
			end
		end
	end

	// storage and response payload
	always_ff @(posedge clock) begin
		if (aw_hs) begin
			aw_addr_q <= awaddr_i;
			aw_size_q <= awsize_i;
		end
		if (w_hs) begin
			w_data_q <= wdata_i;
			w_strb_q <= wstrb_i;
		end

		if (ar_hs) begin
			if (ar_ok) begin
				rdata_o <= mem[araddr_i[IDX_W+1:2]];
				rresp_o <= lsu_pkg::AXI_RESP_OKAY;
			end else begin
				rdata_o <= '0;
				rresp_o <= lsu_pkg::AXI_RESP_SLVERR;
			end
		end

		if (wr_fire) begin
			bresp_o <= wr_ok ? lsu_pkg::AXI_RESP_OKAY : lsu_pkg::AXI_RESP_SLVERR;
			for (int b = 0; b < `DATA_LEN/8; b++) begin
				if (wr_ok && wr_strb[b])
					mem[wr_addr[IDX_W+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

endmodule

/* hdl/lsu_region_cfg.sv */
// lane window bound registers, written through the config port, with the in-window address check
`include "lsu_config.svh"

module lsu_region_cfg (
	input  logic clock,
	input  logic rstn,
	input  logic cfg_valid_i,
	// 0 writes base, 1 writes limit
	input  logic cfg_sel_i,
	input  logic [`ADDR_LEN-1:0] cfg_wdata_i,
	input  logic [`ADDR_LEN-1:0] addr_i,
	output lsu_pkg::win_cfg_t win_o,
	output logic in_window_o
);

	lsu_pkg::win_cfg_t win_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			win_q.base <= `WIN_BASE_RST;
			win_q.limit <= `WIN_LIMIT_RST;
		end else if (cfg_valid_i) begin
			if (cfg_sel_i)
				win_q.limit <= cfg_wdata_i;
			else
				win_q.base <= cfg_wdata_i;
		end
	end

	// both bounds inclusive
	assign in_window_o = (addr_i >= win_q.base) && (addr_i <= win_q.limit);

	assign win_o = win_q;

endmodule

/* lsu/lsu_ctrl.sv */
// request FSM of the memory stage; turns one request at a time into AXI-lite traffic and a writeback
`include "lsu_config.svh"

module lsu_ctrl (
	input  logic clock,
	input  logic rstn,
	// execute side
	input  logic req_valid_i,
	input  lsu_pkg::lsu_req_t req_i,
	output logic req_ready_o,
	// writeback side
	output logic rsp_valid_o,
	output lsu_pkg::lsu_rsp_t rsp_o,
	input  logic rsp_ready_i,
	// address read
	output logic [`ADDR_LEN-1:0] araddr_o,
	output lsu_pkg::axi_size_e arsize_o,
	output logic arvalid_o,
	input  logic arready_i,
	// read data
	input  logic [`DATA_LEN-1:0] rdata_i,
	input  logic [1:0] rresp_i,
	input  logic rvalid_i,
	output logic rready_o,
	// address write
	output logic [`ADDR_LEN-1:0] awaddr_o,
	output lsu_pkg::axi_size_e awsize_o,
	output logic awvalid_o,
	input  logic awready_i,
	// write data
	output logic [`DATA_LEN-1:0] wdata_o,
	output logic [`DATA_LEN/8-1:0] wstrb_o,
	output logic wvalid_o,
	input  logic wready_i,
	// write response
	input  logic [1:0] bresp_i,
	input  logic bvalid_i,
	output logic bready_o,
	// lane aligner
	output lsu_pkg::mem_op_e al_op_o,
	output logic [`ADDR_LEN-1:0] al_addr_o,
	output logic [`DATA_LEN-1:0] al_wdata_o,
	output logic [`DATA_LEN-1:0] al_rdata_o,
	input  logic [`DATA_LEN-1:0] al_lane_wdata_i,
	input  logic [`DATA_LEN/8-1:0] al_strb_i,
	input  logic [`DATA_LEN-1:0] al_load_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_RESP,
		ST_DONE
	} state_e;

	state_e state_q;
	lsu_pkg::lsu_req_t req_q;
	logic [`DATA_LEN-1:0] rdata_q;
	logic err_q;
	logic ar_valid_q;
	logic aw_valid_q;
	logic w_valid_q;
	logic is_load;
	logic is_store;
	logic req_hs;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic r_hs;
	logic b_hs;
	logic rsp_hs;
	logic wr_addr_done;
	lsu_pkg::axi_size_e size;

	function automatic logic op_is_load(lsu_pkg::mem_op_e op);
		return op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
			lsu_pkg::OP_LBU, lsu_pkg::OP_LHU};
	endfunction

	function automatic logic op_is_store(lsu_pkg::mem_op_e op);
		return op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
	endfunction

	assign is_load = op_is_load(req_q.op);
	assign is_store = op_is_store(req_q.op);

	// size follows the access width of the op
	always_comb begin
		case (req_q.op)
			lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: size = lsu_pkg::AXI_SIZE_1;
			lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: size = lsu_pkg::AXI_SIZE_2;
			default: size = lsu_pkg::AXI_SIZE_4;
		endcase
	end

	assign req_ready_o = (state_q == ST_IDLE);
	assign rsp_valid_o = (state_q == ST_DONE);
	assign rready_o = (state_q == ST_RESP) && is_load;
	assign bready_o = (state_q == ST_RESP) && is_store;

	assign req_hs = req_valid_i && req_ready_o;
	assign ar_hs = arvalid_o && arready_i;
	assign aw_hs = awvalid_o && awready_i;
	assign w_hs = wvalid_o && wready_i;
	assign r_hs = rvalid_i && rready_o;
	assign b_hs = bvalid_i && bready_o;
	assign rsp_hs = rsp_valid_o && rsp_ready_i;

	// aw and w may be taken in different cycles
	assign wr_addr_done = (!aw_valid_q || awready_i) && (!w_valid_q || wready_i);

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			ar_valid_q <= 1'b0;
			aw_valid_q <= 1'b0;
			w_valid_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req_hs) begin
						if (op_is_load(req_i.op)) begin
							ar_valid_q <= 1'b1;
							state_q <= ST_ADDR;
						end else if (op_is_store(req_i.op)) begin
							aw_valid_q <= 1'b1;
							w_valid_q <= 1'b1;
							state_q <= ST_ADDR;
						end else begin
							// pass-through goes straight to writeback
							state_q <= ST_DONE;
						end
					end
				end
				ST_ADDR: begin
					if (ar_hs)
						ar_valid_q <= 1'b0;
					if (aw_hs)
						aw_valid_q <= 1'b0;
					if (w_hs)
						w_valid_q <= 1'b0;
					if (is_load ? ar_hs : wr_addr_done)
						state_q <= ST_RESP;
				end
				ST_RESP: begin
					if (r_hs || b_hs)
						state_q <= ST_DONE;
				end
				ST_DONE: begin
					if (rsp_hs)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clock) begin
		if (req_hs) begin
			req_q <= req_i;
			err_q <= 1'b0;
		end
		if (r_hs) begin
			rdata_q <= rdata_i;
			err_q <= (rresp_i != lsu_pkg::AXI_RESP_OKAY);
		end
		if (b_hs)
			err_q <= (bresp_i != lsu_pkg::AXI_RESP_OKAY);
	end

	assign arvalid_o = ar_valid_q;
	assign awvalid_o = aw_valid_q;
	assign wvalid_o = w_valid_q;
	assign araddr_o = req_q.addr;
	assign awaddr_o = req_q.addr;
	assign arsize_o = size;
	assign awsize_o = size;
	assign wdata_o = al_lane_wdata_i;
	assign wstrb_o = al_strb_i;

	assign al_op_o = req_q.op;
	assign al_addr_o = req_q.addr;
	assign al_wdata_o = req_q.wdata;
	// raw word; the aligner picks the lane and extends it
	assign al_rdata_o = rdata_q;

	always_comb begin
		rsp_o.rd = req_q.rd;
		rsp_o.wd = req_q.wd;
		rsp_o.wdata = is_load ? al_load_i : req_q.wdata;
		rsp_o.err = err_q;
	end

endmodule

/* lsu/lsu_lane_align.sv */
// combinational byte-lane placement for stores and lane extraction plus extension for loads
`include "lsu_config.svh"

module lsu_lane_align (
	input  lsu_pkg::mem_op_e op_i,
	input  logic [1:0] addr_lo_i,
	input  logic in_window_i,
	input  logic [`DATA_LEN-1:0] wdata_i,
	input  logic [`DATA_LEN-1:0] rdata_i,
	output logic [`DATA_LEN-1:0] lane_wdata_o,
	output logic [`DATA_LEN/8-1:0] strb_o,
	output logic [`DATA_LEN-1:0] load_o
);

	logic [1:0] lane;
	logic [`DATA_LEN/8-1:0] strb_base;
	lsu_pkg::mem_word_u st_src;
	lsu_pkg::mem_word_u st_dst;
	lsu_pkg::mem_word_u ld_src;
	lsu_pkg::mem_word_u ld_lane;

	// device-style access outside the window keeps everything at lane 0
	assign lane = in_window_i ? addr_lo_i : 2'b00;

	always_comb begin
		case (op_i)
			lsu_pkg::OP_SB: strb_base = 4'b0001;
			lsu_pkg::OP_SH: strb_base = 4'b0011;
			lsu_pkg::OP_SW: strb_base = 4'b1111;
			default: strb_base = 4'b0000;
		endcase
	end

	assign strb_o = strb_base << lane;

	// store bytes move up by lane
	always_comb begin
		st_src.word = wdata_i;
		st_dst.word = '0;
		for (int i = 0; i < `DATA_LEN/8; i++) begin
			if (i >= int'(lane))
				st_dst.bytes[i] = st_src.bytes[i - int'(lane)];
		end
	end

	assign lane_wdata_o = st_dst.word;

	// load bytes come down from lane
	always_comb begin
		ld_src.word = rdata_i;
		ld_lane.word = '0;
		for (int i = 0; i < `DATA_LEN/8; i++) begin
			if (i + int'(lane) < `DATA_LEN/8)
				ld_lane.bytes[i] = ld_src.bytes[i + int'(lane)];
		end
	end

	always_comb begin
		case (op_i)
			lsu_pkg::OP_LB: load_o = {{24{ld_lane.word[7]}}, ld_lane.word[7:0]};
			lsu_pkg::OP_LH: load_o = {{16{ld_lane.word[15]}}, ld_lane.word[15:0]};
			lsu_pkg::OP_LBU: load_o = {24'b0, ld_lane.word[7:0]};
			lsu_pkg::OP_LHU: load_o = {16'b0, ld_lane.word[15:0]};
			// LW and anything else pass the word as is
			default: load_o = ld_lane.word;
		endcase
	end

endmodule

/* common/lsu_pkg.sv */
// shared types of the memory stage; referenced by scoped name from the RTL and testbench
`include "lsu_config.svh"

package lsu_pkg;

	// memory operation carried with each request
	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LH   = 4'd2,
		OP_LW   = 4'd3,
		OP_LBU  = 4'd4,
		OP_LHU  = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} mem_op_e;

	// AXI size field, bytes = 2**size
	typedef enum logic [2:0] {
		AXI_SIZE_1 = 3'd0,
		AXI_SIZE_2 = 3'd1,
		AXI_SIZE_4 = 3'd2
	} axi_size_e;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	// request from execute; wdata is store data or the ALU result
	typedef struct packed {
		mem_op_e op;
		logic [`ADDR_LEN-1:0] addr;
		logic [`DATA_LEN-1:0] wdata;
		logic [4:0] rd;
		logic wd;
	} lsu_req_t;

	// writeback record
	typedef struct packed {
		logic [4:0] rd;
		logic wd;
		logic [`DATA_LEN-1:0] wdata;
		logic err;
	} lsu_rsp_t;

	// one data word, seen whole or as byte lanes
	typedef union packed {
		logic [`DATA_LEN-1:0] word;
		logic [`DATA_LEN/8-1:0][7:0] bytes;
	} mem_word_u;

	// lane window bounds, inclusive
	typedef struct packed {
		logic [`ADDR_LEN-1:0] base;
		logic [`ADDR_LEN-1:0] limit;
	} win_cfg_t;

endpackage

/* common/lsu_config.svh */
// width, SRAM depth and reset window macros; include in any file that sizes ports or storage
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// datapath and address widths
`define DATA_LEN 32
`define ADDR_LEN 32

// depth of the built-in AXI-lite SRAM, in 32-bit words
`define SRAM_WORDS 64

// lane window after reset, both bounds inclusive
// covers the whole built-in SRAM
`define WIN_BASE_RST 32'h0000_0000
`define WIN_LIMIT_RST 32'h0000_00FF

`endif
